// ==== rtl/vram_pkg.sv ====
`default_nettype none

package vram_pkg;

	localparam int vram_addr_w = 13;	// 8 KiB
	localparam int vram_data_w = 8;

	localparam int oam_bytes = 160;	// 40 sprites, 4 bytes each

	// cpu reads see a floating bus while the picture unit renders
	localparam logic [vram_data_w-1:0] open_bus_data = 8'hff;

	// owner of the access that sits at the memory
	typedef enum logic [1:0] {
		idle      = 2'd0,
		cpu_cycle = 2'd1,
		dma_cycle = 2'd2
	} arb_state_t;

endpackage

`default_nettype wire

// ==== rtl/cpu_req_fifo.sv ====
`default_nettype none
`timescale 1ns/100ps

module cpu_req_fifo #(
	parameter int fifo_depth = 4
) (
	input  logic clk,
	input  logic rst_n,
	input  logic cpu_req_valid,
	input  logic cpu_req_write,
	input  logic [vram_pkg::vram_addr_w-1:0] cpu_req_addr,
	input  logic [vram_pkg::vram_data_w-1:0] cpu_req_wdata,
	input  logic cpu_pop,
	output logic head_valid,
	output logic head_write,
	output logic [vram_pkg::vram_addr_w-1:0] head_addr,
	output logic [vram_pkg::vram_data_w-1:0] head_wdata,
	output logic cpu_credit
);

	localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
	localparam int cnt_w = $clog2(fifo_depth + 1);
	localparam int entry_w = 1 + vram_pkg::vram_addr_w + vram_pkg::vram_data_w;

	logic [entry_w-1:0] entries [fifo_depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] fill;

	function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] ptr);
		if (ptr == ptr_w'(fifo_depth - 1))
			return '0;	// wrap, depth need not be a power of two
		return ptr + 1'b1;
	endfunction

	assign head_valid = (fill != '0);
	assign {head_write, head_addr, head_wdata} = entries[rd_ptr];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
			cpu_credit <= 1'b0;
		end else begin
			if (cpu_req_valid)
				wr_ptr <= ptr_next(wr_ptr);
			if (cpu_pop)
				rd_ptr <= ptr_next(rd_ptr);
			fill <= fill + cnt_w'(cpu_req_valid) - cnt_w'(cpu_pop);
			cpu_credit <= cpu_pop;	// one credit back per removed entry
		end
	end

	always_ff @(posedge clk) begin
		if (cpu_req_valid)
			entries[wr_ptr] <= {cpu_req_write, cpu_req_addr, cpu_req_wdata};
	end

	// cpu must hold a credit before it pushes
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		!(cpu_req_valid && (fill == cnt_w'(fifo_depth))));

	// arbiter pops only a presented head
	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_pop |-> head_valid);

endmodule

`default_nettype wire

// ==== rtl/dma_counter.sv ====
`default_nettype none
`timescale 1ns/100ps

module dma_counter (
	input  logic clk,
	input  logic rst_n,
	input  logic dma_start,
	input  logic [4:0] dma_src_page,
	input  logic dma_step,
	output logic dma_busy,
	output logic [vram_pkg::vram_addr_w-1:0] dma_addr,
	output logic [7:0] dma_index,
	output logic dma_last
);

	logic run;
	logic [1:0] drain;	// read pipeline depth after the last step
	logic [7:0] count;
	logic [4:0] page;
	logic start_ok;

	assign start_ok = dma_start && !dma_busy;	// restart ignored mid copy
	assign dma_busy = run || (drain != 2'd0);
	assign dma_last = run && (count == 8'(vram_pkg::oam_bytes - 1));
	assign dma_index = count;
	assign dma_addr = {page, count};	// page * 256 + count

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			run <= 1'b0;
			drain <= 2'd0;
			count <= 8'd0;
		end else if (start_ok) begin
			run <= 1'b1;
			count <= 8'd0;
		end else if (run && dma_step) begin
			if (dma_last) begin
				run <= 1'b0;
				drain <= 2'd2;
			end else begin
				count <= count + 8'd1;
			end
		end else if (drain != 2'd0) begin
			drain <= drain - 2'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (start_ok)
			page <= dma_src_page;
	end

	a_count_range: assert property (@(posedge clk) disable iff (!rst_n)
		dma_busy |-> (count < 8'(vram_pkg::oam_bytes)));

	// arbiter stops granting once the last byte is out
	a_step_in_run: assert property (@(posedge clk) disable iff (!rst_n)
		dma_step |-> run);

endmodule

`default_nettype wire

// ==== rtl/vram_arbiter_fsm.sv ====
`default_nettype none
`timescale 1ns/100ps

module vram_arbiter_fsm (
	input  logic clk,
	input  logic rst_n,
	input  logic ppu_busy,
	input  logic ppu_fetch_req,
	input  logic [vram_pkg::vram_addr_w-1:0] ppu_fetch_addr,
	input  logic head_valid,
	input  logic head_write,
	input  logic [vram_pkg::vram_addr_w-1:0] head_addr,
	input  logic [vram_pkg::vram_data_w-1:0] head_wdata,
	output logic cpu_pop,
	input  logic dma_busy,
	input  logic [vram_pkg::vram_addr_w-1:0] dma_addr,
	input  logic [7:0] dma_index,
	input  logic dma_last,
	output logic dma_step,
	output logic ram_we,
	output logic [vram_pkg::vram_addr_w-1:0] ram_addr,
	output logic [vram_pkg::vram_data_w-1:0] ram_wdata,
	input  logic [vram_pkg::vram_data_w-1:0] ram_rdata,
	output logic cpu_rsp_valid,
	output logic [vram_pkg::vram_data_w-1:0] cpu_rsp_data,
	output logic ppu_fetch_valid,
	output logic [vram_pkg::vram_data_w-1:0] ppu_fetch_data,
	output logic oam_we,
	output logic [7:0] oam_index,
	output logic [vram_pkg::vram_data_w-1:0] oam_wdata
);

	vram_pkg::arb_state_t state;
	vram_pkg::arb_state_t next_state;
	vram_pkg::arb_state_t st2_state;
	logic dma_tail;
	logic dma_active;
	logic st1_fetch;
	logic st2_fetch;
	logic st1_wr;
	logic st2_wr;
	logic st1_open;
	logic st2_open;
	logic [7:0] st1_index;
	logic [7:0] st2_index;

	// counter keeps dma_busy up while the last bytes drain
	assign dma_active = dma_busy && !dma_tail;

	// fixed priority with the fetcher first
	assign dma_step = !ppu_fetch_req && dma_active;
	assign cpu_pop = !ppu_fetch_req && !dma_active && head_valid;

	always_comb begin
		if (dma_step)
			next_state = vram_pkg::dma_cycle;
		else if (cpu_pop)
			next_state = vram_pkg::cpu_cycle;
		else
			next_state = vram_pkg::idle;	// fetch or no access
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= vram_pkg::idle;
			st2_state <= vram_pkg::idle;
			st1_fetch <= 1'b0;
			st2_fetch <= 1'b0;
			ram_we <= 1'b0;
			dma_tail <= 1'b0;
		end else begin
			state <= next_state;
			st2_state <= state;
			st1_fetch <= ppu_fetch_req;
			st2_fetch <= st1_fetch;
			ram_we <= cpu_pop && head_write && !ppu_busy;	// rendering drops writes
			dma_tail <= dma_busy && (dma_tail || (dma_step && dma_last));
		end
	end

	always_ff @(posedge clk) begin
		if (ppu_fetch_req)
			ram_addr <= ppu_fetch_addr;
		else if (dma_active)
			ram_addr <= dma_addr;
		else
			ram_addr <= head_addr;
		ram_wdata <= head_wdata;
		st1_wr <= head_write;
		st2_wr <= st1_wr;
		st1_open <= ppu_busy;	// sampled at grant
		st2_open <= st1_open;
		st1_index <= dma_index;
		st2_index <= st1_index;
	end

	assign ppu_fetch_valid = st2_fetch;
	assign ppu_fetch_data = ram_rdata;

	assign cpu_rsp_valid = (st2_state == vram_pkg::cpu_cycle) && !st2_wr;
	assign cpu_rsp_data = st2_open ? vram_pkg::open_bus_data : ram_rdata;

	assign oam_we = (st2_state == vram_pkg::dma_cycle);
	assign oam_index = st2_index;
	assign oam_wdata = ram_rdata;

	a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({ppu_fetch_req, dma_step, cpu_pop}));

endmodule

`default_nettype wire

// ==== rtl/vram_ram.sv ====
`default_nettype none
`timescale 1ns/100ps

module vram_ram (
	input  logic clk,
	input  logic we,
	input  logic [vram_pkg::vram_addr_w-1:0] addr,
	input  logic [vram_pkg::vram_data_w-1:0] wdata,
	output logic [vram_pkg::vram_data_w-1:0] rdata
);

	logic [vram_pkg::vram_data_w-1:0] mem [2**vram_pkg::vram_addr_w];

	always_ff @(posedge clk) begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr];	// old data on a same cycle write
	end

endmodule

`default_nettype wire

// ==== rtl/vram_subsystem.sv ====
`default_nettype none
`timescale 1ns/100ps

module vram_subsystem #(
	parameter int fifo_depth = 4
) (
	input  logic clk,
	input  logic rst_n,
	input  logic cpu_req_valid,
	input  logic cpu_req_write,
	input  logic [vram_pkg::vram_addr_w-1:0] cpu_req_addr,
	input  logic [vram_pkg::vram_data_w-1:0] cpu_req_wdata,
	output logic cpu_credit,
	output logic cpu_rsp_valid,
	output logic [vram_pkg::vram_data_w-1:0] cpu_rsp_data,
	input  logic ppu_busy,
	input  logic ppu_fetch_req,
	input  logic [vram_pkg::vram_addr_w-1:0] ppu_fetch_addr,
	output logic ppu_fetch_valid,
	output logic [vram_pkg::vram_data_w-1:0] ppu_fetch_data,
	input  logic dma_start,
	input  logic [4:0] dma_src_page,
	output logic dma_busy,
	output logic oam_we,
	output logic [7:0] oam_index,
	output logic [vram_pkg::vram_data_w-1:0] oam_wdata
);

	logic head_valid;
	logic head_write;
	logic [vram_pkg::vram_addr_w-1:0] head_addr;
	logic [vram_pkg::vram_data_w-1:0] head_wdata;
	logic cpu_pop;
	logic dma_step;
	logic [vram_pkg::vram_addr_w-1:0] dma_addr;
	logic [7:0] dma_index;
	logic dma_last;
	logic ram_we;
	logic [vram_pkg::vram_addr_w-1:0] ram_addr;
	logic [vram_pkg::vram_data_w-1:0] ram_wdata;
	logic [vram_pkg::vram_data_w-1:0] ram_rdata;

	cpu_req_fifo #(
		.fifo_depth(fifo_depth)
	) cpu_req_fifo_inst (
		.clk(clk),
		.rst_n(rst_n),
		.cpu_req_valid(cpu_req_valid),
		.cpu_req_write(cpu_req_write),
		.cpu_req_addr(cpu_req_addr),
		.cpu_req_wdata(cpu_req_wdata),
		.cpu_pop(cpu_pop),
		.head_valid(head_valid),
		.head_write(head_write),
		.head_addr(head_addr),
		.head_wdata(head_wdata),
		.cpu_credit(cpu_credit)
	);

	dma_counter dma_counter_inst (
		.clk(clk),
		.rst_n(rst_n),
		.dma_start(dma_start),
		.dma_src_page(dma_src_page),
		.dma_step(dma_step),
		.dma_busy(dma_busy),
		.dma_addr(dma_addr),
		.dma_index(dma_index),
		.dma_last(dma_last)
	);

	vram_arbiter_fsm vram_arbiter_fsm_inst (
		.clk(clk),
		.rst_n(rst_n),
		.ppu_busy(ppu_busy),
		.ppu_fetch_req(ppu_fetch_req),
		.ppu_fetch_addr(ppu_fetch_addr),
		.head_valid(head_valid),
		.head_write(head_write),
		.head_addr(head_addr),
		.head_wdata(head_wdata),
		.cpu_pop(cpu_pop),
		.dma_busy(dma_busy),
		.dma_addr(dma_addr),
		.dma_index(dma_index),
		.dma_last(dma_last),
		.dma_step(dma_step),
		.ram_we(ram_we),
		.ram_addr(ram_addr),
		.ram_wdata(ram_wdata),
		.ram_rdata(ram_rdata),
		.cpu_rsp_valid(cpu_rsp_valid),
		.cpu_rsp_data(cpu_rsp_data),
		.ppu_fetch_valid(ppu_fetch_valid),
		.ppu_fetch_data(ppu_fetch_data),
		.oam_we(oam_we),
		.oam_index(oam_index),
		.oam_wdata(oam_wdata)
	);

	vram_ram vram_ram_inst (
		.clk(clk),
		.we(ram_we),
		.addr(ram_addr),
		.wdata(ram_wdata),
		.rdata(ram_rdata)
	);

endmodule

`default_nettype wire

// ==== test/tb_vram_subsystem.sv ====
`default_nettype none
`timescale 1ns/100ps

module tb_vram_subsystem;

	localparam int fifo_depth = 4;
	localparam int timeout = 2000;	// cycles per wait
	localparam logic [12:0] region_base = 13'h0600;	// pages 6 and 7

	logic clk;
	logic rst_n;
	logic cpu_req_valid;
	logic cpu_req_write;
	logic [12:0] cpu_req_addr;
	logic [7:0] cpu_req_wdata;
	logic cpu_credit;
	logic cpu_rsp_valid;
	logic [7:0] cpu_rsp_data;
	logic ppu_busy;
	logic ppu_fetch_req;
	logic [12:0] ppu_fetch_addr;
	logic ppu_fetch_valid;
	logic [7:0] ppu_fetch_data;
	logic dma_start;
	logic [4:0] dma_src_page;
	logic dma_busy;
	logic oam_we;
	logic [7:0] oam_index;
	logic [7:0] oam_wdata;

	logic [7:0] shadow [2**13];
	logic [7:0] exp_rsp [$];
	logic [7:0] exp_fetch_data [$];
	int exp_fetch_due [$];
	logic [12:0] addr_log [32];
	logic [31:0] lcg_state;
	logic [4:0] dma_page_exp;
	int cyc = 0;
	int credits;
	int oam_seen = 0;
	int check_errors = 0;
	int drive_errors;
	int timeouts;

	vram_subsystem #(.fifo_depth(fifo_depth)) vram_subsystem_inst (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
		cyc <= cyc + 1;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic logic [12:0] rand_addr();
		logic [31:0] r;
		r = lcg_next();
		return region_base + 13'(r[24:16]);
	endfunction

	// expected byte for a cpu read issued now
	function automatic logic [7:0] ref_read(input logic [12:0] addr, input logic busy);
		if (busy)
			return vram_pkg::open_bus_data;
		return shadow[addr];
	endfunction

	// clears the input pulses and collects a returned credit
	task automatic tick();
		@(negedge clk);
		cpu_req_valid = 1'b0;
		ppu_fetch_req = 1'b0;
		dma_start = 1'b0;
		if (cpu_credit === 1'b1)
			credits++;
		assert (credits <= fifo_depth) else begin
			drive_errors++;
			$display("%0t: more credits came back than requests were issued", $time);
		end
	endtask

	task automatic push_cpu(input logic write, input logic [12:0] addr, input logic [7:0] data);
		cpu_req_valid = 1'b1;
		cpu_req_write = write;
		cpu_req_addr = addr;
		cpu_req_wdata = data;
		credits--;
		if (!write)
			exp_rsp.push_back(ref_read(addr, ppu_busy));
		else if (!ppu_busy)
			shadow[addr] = data;	// dropped while rendering
	endtask

	task automatic cpu_issue(input logic write, input logic [12:0] addr, input logic [7:0] data);
		int n = 0;
		tick();
		while (credits == 0 && n < timeout) begin
			tick();
			n++;
		end
		if (credits == 0) begin
			timeouts++;
			$display("%0t: no cpu credit came back in time", $time);
		end else begin
			push_cpu(write, addr, data);
		end
	endtask

	task automatic fetch_now(input logic [12:0] addr);
		ppu_fetch_req = 1'b1;
		ppu_fetch_addr = addr;
		exp_fetch_data.push_back(shadow[addr]);
		exp_fetch_due.push_back(cyc + 2);	// grant register and memory read
	endtask

	task automatic wait_idle();
		int n = 0;
		tick();
		while ((credits != fifo_depth || exp_rsp.size() != 0 || exp_fetch_due.size() != 0)
				&& n < timeout) begin
			tick();
			n++;
		end
		if (n == timeout) begin
			timeouts++;
			$display("%0t: cpu queue or responses did not drain", $time);
		end
	endtask

	// outputs are registered and stable at the falling edge
	always @(negedge clk) begin
		if (cpu_rsp_valid === 1'b1) begin
			assert (exp_rsp.size() != 0) else begin
				check_errors++;
				$display("%0t: cpu response arrived with no read pending", $time);
			end
			if (exp_rsp.size() != 0) begin
				assert (cpu_rsp_data == exp_rsp[0]) else begin
					check_errors++;
					$display("** Error at %0t: cpu_rsp_data = %h, expected %h",
						$time, cpu_rsp_data, exp_rsp[0]);
				end
				void'(exp_rsp.pop_front());
			end
		end
		if (exp_fetch_due.size() != 0 && exp_fetch_due[0] == cyc) begin
			assert (ppu_fetch_valid === 1'b1) else begin
				check_errors++;
				$display("%0t: fetch data did not come two cycles after the request", $time);
			end
			assert (ppu_fetch_data == exp_fetch_data[0]) else begin
				check_errors++;
				$display("** Error at %0t: ppu_fetch_data = %h, expected %h",
					$time, ppu_fetch_data, exp_fetch_data[0]);
			end
			void'(exp_fetch_due.pop_front());
			void'(exp_fetch_data.pop_front());
		end else begin
			assert (ppu_fetch_valid !== 1'b1) else begin
				check_errors++;
				$display("%0t: fetch data came with no request due", $time);
			end
		end
		if (oam_we === 1'b1) begin
			assert (dma_busy === 1'b1) else begin
				check_errors++;
				$display("%0t: OAM write came while dma_busy was low", $time);
			end
			assert (oam_index == 8'(oam_seen)) else begin
				check_errors++;
				$display("** Error at %0t: oam_index = %0d, expected %0d",
					$time, oam_index, oam_seen);
			end
			assert (oam_wdata == shadow[{dma_page_exp, 8'(oam_seen)}]) else begin
				check_errors++;
				$display("** Error at %0t: oam_wdata = %h, expected %h",
					$time, oam_wdata, shadow[{dma_page_exp, 8'(oam_seen)}]);
			end
			oam_seen++;
		end else if (oam_seen == vram_pkg::oam_bytes) begin
			assert (dma_busy !== 1'b1) else begin
				check_errors++;
				$display("%0t: dma_busy stayed high after the last OAM write", $time);
			end
		end
	end

	initial begin
		logic [12:0] a;
		logic [31:0] r;
		int n;
		rst_n = 1'b0;
		cpu_req_valid = 1'b0;
		cpu_req_write = 1'b0;
		cpu_req_addr = '0;
		cpu_req_wdata = '0;
		ppu_busy = 1'b0;
		ppu_fetch_req = 1'b0;
		ppu_fetch_addr = '0;
		dma_start = 1'b0;
		dma_src_page = '0;
		dma_page_exp = 5'd6;
		lcg_state = 32'd85924;
		credits = fifo_depth;
		drive_errors = 0;
		timeouts = 0;
		repeat (10) tick();
		assert (!cpu_credit && !cpu_rsp_valid && !ppu_fetch_valid && !oam_we && !dma_busy)
			else begin
				drive_errors++;
				$display("%0t: outputs not inactive during reset", $time);
			end
		rst_n = 1'b1;

		for (int i = 0; i < 512; i++) begin	// known contents for pages 6 and 7
			a = region_base + 13'(i);
			cpu_issue(1'b1, a, a[7:0] ^ {3'b000, a[12:8]});
		end
		wait_idle();

		for (int i = 0; i < 32; i++) begin
			r = lcg_next();
			addr_log[i] = rand_addr();
			cpu_issue(1'b1, addr_log[i], r[15:8]);
		end
		for (int i = 0; i < 32; i++)
			cpu_issue(1'b0, addr_log[i], 8'h00);
		wait_idle();

		ppu_busy = 1'b1;	// rendering
		for (int i = 0; i < 32; i++) begin
			r = lcg_next();
			cpu_issue(r[20], addr_log[i], ~r[15:8]);
		end
		wait_idle();
		ppu_busy = 1'b0;
		for (int i = 0; i < 32; i++)
			cpu_issue(1'b0, addr_log[i], 8'h00);	// old values must survive
		wait_idle();

		n = fifo_depth;	// lowest credit count seen
		for (int i = 0; i < 30; i++) begin
			tick();
			if (i < 12)
				fetch_now(rand_addr());	// stalls the cpu queue
			if (credits > 0)
				push_cpu(1'b0, rand_addr(), 8'h00);
			if (credits < n)
				n = credits;
		end
		assert (n == 0) else begin
			drive_errors++;
			$display("%0t: cpu never ran out of credits during the fetch stall", $time);
		end
		wait_idle();

		dma_start = 1'b1;
		dma_src_page = 5'd6;
		tick();
		assert (dma_busy === 1'b1) else begin
			drive_errors++;
			$display("%0t: dma_busy did not rise after dma_start", $time);
		end
		n = 0;
		while (dma_busy === 1'b1 && n < timeout) begin
			r = lcg_next();
			if (r[17:16] != 2'b00)
				fetch_now(rand_addr());
			if (r[19:18] == 2'b00 && credits > 0)
				push_cpu(1'b0, rand_addr(), 8'h00);
			if (n == 20) begin
				dma_start = 1'b1;	// mid copy restart to be ignored
				dma_src_page = 5'd7;
			end
			tick();
			n++;
		end
		if (n == timeout) begin
			timeouts++;
			$display("%0t: block copy never finished", $time);
		end
		assert (oam_seen == vram_pkg::oam_bytes) else begin
			drive_errors++;
			$display("%0t: block copy wrote %0d OAM bytes instead of %0d",
				$time, oam_seen, vram_pkg::oam_bytes);
		end
		wait_idle();

		$display("errors: compare %0d, protocol %0d, timeout %0d",
			check_errors, drive_errors, timeouts);
		if (check_errors + drive_errors + timeouts == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
rtl/vram_pkg.sv
rtl/cpu_req_fifo.sv
rtl/dma_counter.sv
rtl/vram_arbiter_fsm.sv
rtl/vram_ram.sv
rtl/vram_subsystem.sv
test/tb_vram_subsystem.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the vram subsystem testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
	--top-module tb_vram_subsystem -Mdir obj_dir -f list.f; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_vram_subsystem)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
	exit 0
fi
echo "pass message not found"
exit 1
